// ==== cart_addr_xlate.sv ====
// Fixed-priority CPU to external memory address translation with write blocking
`timescale 1ns/1ps

module cart_addr_xlate (
	input  logic                               reset_n,
	input  logic                               romL,
	input  logic                               romH,
	input  logic                               mem_write,
	input  logic [cart_pkg::ADDR_IN_W-1:0]     addr_in,
	input  cart_pkg::bank_t                    bank_lo,
	input  cart_pkg::bank_t                    bank_hi,
	input  logic                               bank_en,
	input  logic                               exrom_ovr,
	input  logic                               game_ovr,
	output logic [cart_pkg::ADDR_OUT_W-1:0]    addr_out,
	output logic                               mem_write_out,
	output logic                               data_floating
);

	logic ultimax;
	logic romL_rd;
	logic romH_rd;

	assign ultimax = exrom_ovr & ~game_ovr;
	assign romL_rd = romL & ~mem_write & ~reset_n;
	assign romH_rd = romH & ~mem_write & ~reset_n;

	// Ultimax has no RAM under ROML, so writes there go nowhere
	assign mem_write_out = mem_write & ~(romL & ultimax);

	// ************************************************************
	// Address selection, lowest priority first
	// ************************************************************
	always_comb begin
		addr_out      = {cart_pkg::RAM_BASE, addr_in};  // Plain RAM
		data_floating = 1'b0;

		if (romH_rd) begin
			addr_out = {cart_pkg::CRT_BASE, bank_hi, addr_in[cart_pkg::CRT_OFS_W-1:0]};
			data_floating = ~bank_en;
		end

		// ROML wins when both are asserted
		if (romL_rd) begin
			addr_out = {cart_pkg::CRT_BASE, bank_lo, addr_in[cart_pkg::CRT_OFS_W-1:0]};
			data_floating = ~bank_en;  // No cart drives the bus
		end
	end

endmodule

// ==== cart_bank_table.sv ====
// Cartridge bank table filled from CRT chip packets, with packet counter
`timescale 1ns/1ps

module cart_bank_table (
	input  logic                               clk32,
	input  logic                               cart_loading,
	input  logic                               cart_bank_wr,     // One packet per strobe
	input  logic [15:0]                        cart_bank_num,
	input  logic [15:0]                        cart_bank_laddr,  // C64 load address
	input  logic [15:0]                        cart_bank_size,
	input  logic [24:0]                        cart_bank_raddr,  // Packet location in memory
	input  logic [cart_pkg::IDX_W-1:0]         tbl_index,
	output cart_pkg::bank_t                    lo_entry,
	output cart_pkg::bank_t                    hi_entry,
	output logic [cart_pkg::BANK_CNT_W-1:0]    bank_cnt
);

	// ************************************************************
	// Storage
	// ************************************************************
	cart_pkg::bank_t lo_banks [0:cart_pkg::TABLE_DEPTH-1];  // ROML bank per packet number
	cart_pkg::bank_t hi_banks [0:cart_pkg::TABLE_DEPTH-1];  // ROMH bank per packet number

	logic                          old_loading;
	logic                          num_ok;
	logic [cart_pkg::IDX_W-1:0]    wr_index;
	cart_pkg::bank_t               packet_bank;

	assign num_ok      = cart_bank_num < 16'(cart_pkg::TABLE_DEPTH);
	assign wr_index    = cart_bank_num[cart_pkg::IDX_W-1:0];
	assign packet_bank = cart_bank_raddr[19:13];  // 8K granule of the packet

	// ************************************************************
	// Packet counter
	// ************************************************************
	always_ff @(posedge clk32) begin
		old_loading <= cart_loading;

		// New image starts on the rising edge of cart_loading
		if (!old_loading && cart_loading) begin
			bank_cnt <= '0;
		end
		if (cart_bank_wr) begin
			bank_cnt <= bank_cnt + 1'b1;
		end
	end

	// ************************************************************
	// Table fill
	// ************************************************************
	always_ff @(posedge clk32) begin
		if (cart_bank_wr && num_ok) begin
			if (cart_bank_laddr <= cart_pkg::LOAD_LO_LIMIT) begin
				lo_banks[wr_index] <= packet_bank;
				// 16K packet spills into the next 8K bank
				if (cart_bank_size > cart_pkg::BANK_8K) begin
					hi_banks[wr_index] <= packet_bank + 1'b1;
				end
			end else begin
				hi_banks[wr_index] <= packet_bank;  // ROMH only packet
			end
		end
	end

	// Shared combinational read port
	assign lo_entry = lo_banks[tbl_index];
	assign hi_entry = hi_banks[tbl_index];

endmodule

// ==== cart_mapper.sv ====
// Cartridge mapper state: banks, EXROM/GAME lines and per-type bank switching
`timescale 1ns/1ps

module cart_mapper (
	input  logic                               clk32,
	input  logic                               reset_n,
	input  cart_pkg::cart_id_t                 cart_id,
	input  logic [7:0]                         cart_exrom,   // CRT header EXROM
	input  logic [7:0]                         cart_game,    // CRT header GAME
	input  logic                               IOE,
	input  logic                               romL,
	input  logic                               mem_write,
	input  logic [cart_pkg::ADDR_IN_W-1:0]     addr_in,
	input  logic [7:0]                         data_in,
	input  cart_pkg::bank_t                    lo_entry,
	input  cart_pkg::bank_t                    hi_entry,
	input  logic [cart_pkg::BANK_CNT_W-1:0]    bank_cnt,
	output logic [cart_pkg::IDX_W-1:0]         tbl_index,
	output cart_pkg::bank_t                    bank_lo,
	output cart_pkg::bank_t                    bank_hi,
	output logic                               bank_en,
	output logic                               exrom_ovr,
	output logic                               game_ovr
);

	// ************************************************************
	// IOE strobes and configuration change
	// ************************************************************
	logic               ioe_d;
	logic               ioe_stb;
	logic               ioe_wr;
	logic               ioe_rd;
	logic               ef_bank_wr;
	logic               cfg_init;
	logic               init_n;        // Low in the power-on cycle
	cart_pkg::cart_id_t old_id;
	logic [15:0]        epyx_cnt;      // Capacitor charge

	always_ff @(posedge clk32) begin
		ioe_d  <= IOE;
		old_id <= cart_id;
	end

	assign ioe_stb  = IOE & ~ioe_d;  // First IOE cycle only
	assign ioe_wr   = ioe_stb & mem_write;
	assign ioe_rd   = ioe_stb & ~mem_write;
	assign cfg_init = reset_n || (old_id != cart_id);

	// EasyFlash bank register write looks up the table directly
	assign ef_bank_wr = (cart_id == cart_pkg::CART_EASYFLASH) && ioe_wr && !addr_in[1];
	assign tbl_index  = ef_bank_wr ? data_in[cart_pkg::IDX_W-1:0] : '0;

	// ************************************************************
	// Per-type state
	// ************************************************************
	always_ff @(posedge clk32) begin
		init_n <= 1'b1;

		if (cfg_init) begin
			bank_lo   <= '0;
			bank_hi   <= '0;
			bank_en   <= 1'b0;
			exrom_ovr <= 1'b1;
			game_ovr  <= 1'b1;
			epyx_cnt  <= '0;
			init_n    <= 1'b0;
		end else if (cart_id == cart_pkg::CART_NONE) begin
			bank_en <= 1'b0;  // Nothing plugged in
		end else begin
			bank_en <= 1'b1;

			case (cart_id)
				// Lines from the CRT header and banks from entry 0
				cart_pkg::CART_GENERIC: begin
					exrom_ovr <= cart_exrom[0];
					game_ovr  <= cart_game[0];
					bank_lo   <= lo_entry;
					bank_hi   <= hi_entry;
				end

				// 16K mode with the $DE00 bank on both halves
				cart_pkg::CART_OCEAN: begin
					if (!init_n) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b0;
					end
					if (ioe_wr) begin
						bank_lo <= {1'b0, data_in[5:0]};
						bank_hi <= {1'b0, data_in[5:0]};
					end
				end

				// Any access recharges the capacitor and the cart drops out once it is empty
				cart_pkg::CART_EPYX: begin
					if (ioe_wr || ioe_rd || romL) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b1;
						epyx_cnt  <= cart_pkg::EPYX_DISCHARGE;
					end else if (epyx_cnt != 16'd0) begin
						epyx_cnt <= epyx_cnt - 1'b1;
					end else begin
						exrom_ovr <= 1'b1;
					end
				end

				// 8K mode with the bank width set by the image size
				cart_pkg::CART_MAGIC_DESK: begin
					if (!init_n) begin
						exrom_ovr <= 1'b0;
						game_ovr  <= 1'b1;
						bank_lo   <= '0;
					end
					if (ioe_wr) begin
						if (bank_cnt <= 8'd16) begin
							bank_lo <= {3'b000, data_in[3:0]};
						end else if (bank_cnt <= 8'd32) begin
							bank_lo <= {2'b00, data_in[4:0]};
						end else if (bank_cnt <= 8'd64) begin
							bank_lo <= {1'b0, data_in[5:0]};
						end else begin
							bank_lo <= data_in[6:0];
						end
						exrom_ovr <= data_in[7];  // Bit 7 hides the cart
					end
				end

				// Boots in ultimax with the bank at $DE00 and control at $DE02
				cart_pkg::CART_EASYFLASH: begin
					if (!init_n) begin
						exrom_ovr <= 1'b1;
						game_ovr  <= 1'b0;
						bank_lo   <= lo_entry;
						bank_hi   <= hi_entry;
					end
					if (ioe_wr) begin
						if (addr_in[1]) begin
							game_ovr  <= ~data_in[0] & data_in[2];  // Jumper in boot position
							exrom_ovr <= ~data_in[1];
						end else begin
							bank_lo <= lo_entry;
							bank_hi <= hi_entry;
						end
					end
				end

				default: begin
				end
			endcase
		end
	end

endmodule

// ==== cart_pkg.sv ====
// C64 cartridge mapper shared types, type codes, widths and memory bases
package cart_pkg;

	// ************************************************************
	// Field widths
	// ************************************************************
	localparam int BANK_W      = 7;                  // 8K bank index
	localparam int TABLE_DEPTH = 64;                 // Bank table entries
	localparam int IDX_W       = $clog2(TABLE_DEPTH);
	localparam int BANK_CNT_W  = 8;                  // Chip packet counter
	localparam int ADDR_IN_W   = 18;
	localparam int ADDR_OUT_W  = 25;
	localparam int CRT_OFS_W   = 13;                 // Offset inside one 8K bank

	typedef logic [BANK_W-1:0] bank_t;
	typedef logic [15:0]       cart_id_t;

	// ************************************************************
	// Cartridge type codes from the CRT header
	// ************************************************************
	localparam cart_id_t CART_GENERIC    = 16'd0;
	localparam cart_id_t CART_OCEAN      = 16'd5;   // Ocean Type 1
	localparam cart_id_t CART_EPYX       = 16'd10;  // Epyx Fastload
	localparam cart_id_t CART_MAGIC_DESK = 16'd19;
	localparam cart_id_t CART_EASYFLASH  = 16'd32;
	localparam cart_id_t CART_NONE       = 16'd255;

	// ************************************************************
	// External memory layout
	// ************************************************************
	// RAM sits at the bottom, CRT banks start at 1MB
	localparam logic [ADDR_OUT_W-ADDR_IN_W-1:0]        RAM_BASE = 7'h00;
	localparam logic [ADDR_OUT_W-BANK_W-CRT_OFS_W-1:0] CRT_BASE = 5'h01;

	// Epyx capacitor count, reloaded on each access
	localparam logic [15:0] EPYX_DISCHARGE = 16'd16384;

	// CRT chip packet load rules
	localparam logic [15:0] LOAD_LO_LIMIT = 16'h8000;  // Highest ROML load address
	localparam logic [15:0] BANK_8K       = 16'h2000;  // Larger packets also fill ROMH

endpackage

// ==== cartridge.f ====
cart_pkg.sv
cart_bank_table.sv
cart_mapper.sv
cart_addr_xlate.sv
cartridge.sv
cartridge_properties.sv
cartridge_tb.sv

// ==== cartridge.sv ====
// C64 cartridge top level joining bank table, mapper and address translator
`timescale 1ns/1ps

module cartridge (
	input  logic                               clk32,
	input  logic                               reset_n,
	// CRT image load port
	input  logic                               cart_loading,
	input  logic                               cart_bank_wr,
	input  logic [15:0]                        cart_bank_num,
	input  logic [15:0]                        cart_bank_laddr,
	input  logic [15:0]                        cart_bank_size,
	input  logic [24:0]                        cart_bank_raddr,
	// Configuration
	input  cart_pkg::cart_id_t                 cart_id,
	input  logic [7:0]                         cart_exrom,
	input  logic [7:0]                         cart_game,
	// CPU side
	input  logic                               romL,
	input  logic                               romH,
	input  logic                               IOE,
	input  logic                               mem_write,
	input  logic [cart_pkg::ADDR_IN_W-1:0]     addr_in,
	input  logic [7:0]                         data_in,
	output logic                               exrom,
	output logic                               game,
	output logic [cart_pkg::ADDR_OUT_W-1:0]    addr_out,
	output logic                               mem_write_out,
	output logic                               data_floating
);

	// ************************************************************
	// Internal wiring
	// ************************************************************
	cart_pkg::bank_t                    lo_entry;
	cart_pkg::bank_t                    hi_entry;
	logic [cart_pkg::BANK_CNT_W-1:0]    bank_cnt;
	logic [cart_pkg::IDX_W-1:0]         tbl_index;
	cart_pkg::bank_t                    bank_lo;
	cart_pkg::bank_t                    bank_hi;
	logic                               bank_en;

	cart_bank_table i_bank_table (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.tbl_index       (tbl_index),
		.lo_entry        (lo_entry),
		.hi_entry        (hi_entry),
		.bank_cnt        (bank_cnt)
	);

	cart_mapper i_mapper (
		.clk32      (clk32),
		.reset_n    (reset_n),
		.cart_id    (cart_id),
		.cart_exrom (cart_exrom),
		.cart_game  (cart_game),
		.IOE        (IOE),
		.romL       (romL),
		.mem_write  (mem_write),
		.addr_in    (addr_in),
		.data_in    (data_in),
		.lo_entry   (lo_entry),
		.hi_entry   (hi_entry),
		.bank_cnt   (bank_cnt),
		.tbl_index  (tbl_index),
		.bank_lo    (bank_lo),
		.bank_hi    (bank_hi),
		.bank_en    (bank_en),
		.exrom_ovr  (exrom),     // Lines go straight to the expansion port
		.game_ovr   (game)
	);

	cart_addr_xlate i_addr_xlate (
		.reset_n       (reset_n),
		.romL          (romL),
		.romH          (romH),
		.mem_write     (mem_write),
		.addr_in       (addr_in),
		.bank_lo       (bank_lo),
		.bank_hi       (bank_hi),
		.bank_en       (bank_en),
		.exrom_ovr     (exrom),
		.game_ovr      (game),
		.addr_out      (addr_out),
		.mem_write_out (mem_write_out),
		.data_floating (data_floating)
	);

endmodule

// ==== cartridge_properties.sv ====
// Cartridge top level assertions on write blocking, reset lines and ROML mapping
`timescale 1ns/1ps

module cartridge_properties (
	input logic                            clk32,
	input logic                            reset_n,
	input logic                            romL,
	input logic                            mem_write,
	input logic                            mem_write_out,
	input logic                            exrom,
	input logic                            game,
	input logic [cart_pkg::ADDR_OUT_W-1:0] addr_out
);

	// Ultimax has no RAM under ROML
	write_blocked: assert property (@(posedge clk32)
		(romL && exrom && !game) |-> !mem_write_out)
		else $error("mem_write_out high under ROML in ultimax");

	reset_lines: assert property (@(posedge clk32) reset_n |=> (exrom && game))
		else $error("exrom or game low after reset");

	// ROML read always lands in the CRT area
	roml_base: assert property (@(posedge clk32)
		(romL && !mem_write && !reset_n) |-> (addr_out[24:20] == cart_pkg::CRT_BASE))
		else $error("ROML read outside the CRT area");

endmodule

bind cartridge cartridge_properties i_properties (
	.clk32         (clk32),
	.reset_n       (reset_n),
	.romL          (romL),
	.mem_write     (mem_write),
	.mem_write_out (mem_write_out),
	.exrom         (exrom),
	.game          (game),
	.addr_out      (addr_out)
);

// ==== cartridge_stim.txt ====
# Values in hex. load num laddr size raddr | config id exrom game | wait cycles
# access romL romH IOE mem_write addr data | expect signal value | end name
load 0 8000 4000 104000
config 0 0 0
wait 3
expect exrom 0
expect game 0
access 1 0 0 0 8123 0
expect addr_out 104123
access 0 1 0 0 a456 0
expect addr_out 106456
end generic

config 5 0 0
wait 3
expect exrom 0
access 0 0 1 1 de00 05
access 1 0 0 0 8010 0
expect addr_out 10a010
access 0 1 0 0 bfff 0
expect addr_out 10bfff
end ocean

load 0 8000 2000 100000
load 1 8000 2000 102000
load 2 8000 2000 104000
config 13 0 0
wait 3
access 0 0 1 1 de00 bd
expect exrom 1
access 1 0 0 0 8000 0
expect addr_out 11a000
end magic_desk

load 5 8000 2000 120000
load 5 e000 2000 122000
config 20 0 0
wait 3
access 0 0 1 1 de00 05
access 1 0 0 0 8100 0
expect addr_out 120100
access 0 1 0 0 a200 0
expect addr_out 122200
access 0 0 1 1 de02 07
expect exrom 0
expect game 0
access 0 0 1 1 de02 00
expect exrom 1
access 1 0 0 1 8000 aa
expect mem_write_out 0
end easyflash

config a 0 0
wait 3
access 0 0 1 0 df00 0
expect exrom 0
wait 3e80
expect exrom 0
wait 1f4
expect exrom 1
end epyx

config ff 0 0
wait 3
access 1 0 0 0 8000 0
expect data_floating 1
access 0 0 0 0 1234 0
expect addr_out 1234
expect data_floating 0
end no_cart

// ==== cartridge_tb.sv ====
// Cartridge mapper testbench driven by records from the stim file
`timescale 1ns/1ps

module cartridge_tb;

	localparam longint CLK_PERIOD = 100;
	localparam longint REC_CYCLES = 200;  // Allowance per stim record

	logic                            clk32;
	logic                            reset_n;
	logic                            cart_loading;
	logic                            cart_bank_wr;
	logic [15:0]                     cart_bank_num, cart_bank_laddr, cart_bank_size;
	logic [24:0]                     cart_bank_raddr;
	cart_pkg::cart_id_t              cart_id;
	logic [7:0]                      cart_exrom, cart_game;
	logic                            romL, romH, IOE, mem_write;
	logic [cart_pkg::ADDR_IN_W-1:0]  addr_in;
	logic [7:0]                      data_in;
	logic                            exrom, game, mem_write_out, data_floating;
	logic [cart_pkg::ADDR_OUT_W-1:0] addr_out;

	logic [8*128-1:0] records [$];  // Stim lines without comments
	longint           wd_limit;
	logic             wd_armed;
	int               err_total, err_test, test_cnt, test_fail;

	cartridge i_cartridge (.*);

	always #(CLK_PERIOD/2) clk32 = ~clk32;

	// ************************************************************
	// Stim file, check and bus tasks
	// ************************************************************
	task automatic read_stim();
		int               fd;
		int               n;
		logic [8*128-1:0] line;
		logic [8*16-1:0]  kw;
		logic [31:0]      cycles;
		longint           wait_sum;
		wait_sum = 0;
		fd = $fopen("cartridge_stim.txt", "r");
		if (fd == 0) begin
			$display("Cannot open cartridge_stim.txt");
			err_total++;
		end else begin
			while (!$feof(fd)) begin
				line = '0;
				kw   = '0;
				n    = $fgets(line, fd);
				if (n > 0) n = $sscanf(line, "%s", kw);
				if (n > 0 && kw != "#") begin
					records.push_back(line);
					if (kw == "wait") begin
						n = $sscanf(line, "%s %h", kw, cycles);
						wait_sum += cycles;  // Long waits stretch the watchdog
					end
				end
			end
			$fclose(fd);
		end
		wd_limit = (wait_sum + REC_CYCLES * records.size()) * CLK_PERIOD;
	endtask

	task automatic check_value(input logic [8*16-1:0] name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0s: got 0x%0h, expected 0x%0h", name, actual, expected);
			err_test++;
		end
	endtask

	task automatic cpu_access(input logic [31:0] l, h, ioe, wr, addr, data);
		@(negedge clk32);
		romL      = l[0];
		romH      = h[0];
		IOE       = ioe[0];
		mem_write = wr[0];
		addr_in   = addr[cart_pkg::ADDR_IN_W-1:0];
		data_in   = data[7:0];
		if (ioe[0]) begin  // One IOE cycle, then let the mapper settle
			@(negedge clk32);
			IOE       = 1'b0;
			mem_write = 1'b0;
			repeat (2) @(negedge clk32);
		end
	endtask

	task automatic run_record(input logic [8*128-1:0] rec);
		logic [8*16-1:0] kw;
		logic [8*16-1:0] word;
		logic [31:0]     a0, a1, a2, a3, a4, a5;
		int              n;
		n = $sscanf(rec, "%s %h %h %h %h %h %h", kw, a0, a1, a2, a3, a4, a5);
		case (kw)
			"load": begin
				if (!cart_loading) begin
					@(negedge clk32);
					cart_loading = 1'b1;  // Rising edge clears the packet count
				end
				@(negedge clk32);
				cart_bank_wr    = 1'b1;
				cart_bank_num   = a0[15:0];
				cart_bank_laddr = a1[15:0];
				cart_bank_size  = a2[15:0];
				cart_bank_raddr = a3[24:0];
				@(negedge clk32);
				cart_bank_wr = 1'b0;
			end
			"config": begin
				@(negedge clk32);
				cart_loading = 1'b0;
				cart_id      = a0[15:0];
				cart_exrom   = a1[7:0];
				cart_game    = a2[7:0];
			end
			"access": cpu_access(a0, a1, a2, a3, a4, a5);
			"wait": repeat (a0) @(negedge clk32);
			"expect": begin
				n = $sscanf(rec, "%s %s %h", kw, word, a0);
				#1;
				case (word)
					"exrom":         check_value(word, 32'(exrom), a0);
					"game":          check_value(word, 32'(game), a0);
					"addr_out":      check_value(word, 32'(addr_out), a0);
					"mem_write_out": check_value(word, 32'(mem_write_out), a0);
					"data_floating": check_value(word, 32'(data_floating), a0);
					default: begin
						$display("Stim file names an unknown signal %0s", word);
						err_test++;
					end
				endcase
			end
			"end": begin
				n = $sscanf(rec, "%s %s", kw, word);
				cpu_access(0, 0, 0, 0, 0, 0);  // Idle bus between tests
				$display("Test %0s: %0s, %0d errors", word, (err_test == 0) ? "pass" : "FAIL",
					err_test);
				test_cnt++;
				if (err_test != 0) test_fail++;
				err_total += err_test;
				err_test = 0;
			end
			default: begin
				$display("Stim file has a record that cannot be parsed");
				err_test++;
			end
		endcase
	endtask

	// ************************************************************
	// Main sequence and watchdog
	// ************************************************************
	initial begin
		clk32 = 1'b0;
		reset_n = 1'b1;
		{cart_loading, cart_bank_wr, cart_bank_num, cart_bank_laddr} = '0;
		{cart_bank_size, cart_bank_raddr, cart_id, cart_exrom, cart_game} = '0;
		{romL, romH, IOE, mem_write, addr_in, data_in} = '0;
		{err_total, err_test, test_cnt, test_fail} = '0;
		wd_armed = 1'b0;
		read_stim();
		wd_armed = 1'b1;
		repeat (2) @(posedge clk32);
		@(negedge clk32);
		reset_n = 1'b0;
		foreach (records[i]) run_record(records[i]);
		err_total += err_test;
		$display("Summary: %0d tests, %0d failed, %0d errors", test_cnt, test_fail, err_total);
		if (err_total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		wait (wd_armed);
		#(wd_limit);
		$display("Timeout: the tests did not finish within %0d ns", wd_limit);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the cartridge testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module cartridge_tb \
	-f cartridge.f -o cartridge_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/cartridge_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1
